// ==== build.f ====
+incdir+src
src/tile_bus_pkg.sv
src/tile_addr_pkg.sv
src/tile_addr_demux.sv
src/l1_spm.sv
src/l2_bridge.sv
src/compute_tile.sv
verification/tb_l2_memory.sv
verification/tb_compute_tile.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the compute tile testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f build.f \
  --top-module tb_compute_tile \
  -o tb_compute_tile

./obj_dir/tb_compute_tile | tee "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"

// ==== verification/tb_compute_tile.sv ====
// Testbench for the compute tile
// Clock, reset, directed and random stimulus, reference model of L1 and L2,
// expected-response FIFO, concurrent check assertions, timeout and summary

`timescale 1ns/100ps

`include "tile_cfg.svh"

module tb_compute_tile;

  import tile_addr_pkg::*;

  localparam int          TIMEOUT_CYCLES = 2000;          // About four times the test length
  localparam logic [31:0] L2_FILL_KEY    = 32'hc3a5_5a3c;  // Must match the L2 model fill

  logic        clk_i = 1'b0;
  logic        rstn_i;
  logic        tile_enable_i;
  logic        data_req_i;
  logic [31:0] data_addr_i;
  logic        data_we_i;
  logic [3:0]  data_be_i;
  logic [31:0] data_wdata_i;
  logic        data_gnt_o;
  logic        data_rvalid_o;
  logic [31:0] data_rdata_o;
  logic        data_err_o;
  logic        l2_req_o;
  logic        l2_we_o;
  logic        l2_gnt_i;
  logic        l2_rvalid_i;
  logic        l2_err_i;
  logic [31:0] l2_addr_o;
  logic [31:0] l2_wdata_o;
  logic [31:0] l2_rdata_i;
  logic [3:0]  l2_be_o;

  logic [31:0] l1_ref [0:255] = '{default: '1};  // L1 words, power-up all ones
  logic [31:0] l2_ref [logic [31:0]];             // Written L2 words
  logic [31:0] exp_rdata [0:255];                 // Expected responses, circular
  logic        exp_err [0:255];
  logic        exp_l2 [0:255];
  logic [7:0]  wr_ptr = '0;
  logic [7:0]  rd_ptr = '0;
  int          exp_cnt = 0;
  logic        l2_pend = 1'b0;   // L2 request accepted, response not yet seen
  logic        en_q;             // Own copy of the registered enable
  int          mismatch_cnt = 0;
  int          other_cnt = 0;
  int          rsp_cnt = 0;
  int          cycle_cnt = 0;
  logic [31:0] head_rdata;
  logic        head_err;
  logic        acc;
  logic        acc_local;

  always #50 clk_i = ~clk_i;     // 100 ns period

  compute_tile i_dut (.*);

  tb_l2_memory i_l2_mem (
    .clk_i    ( clk_i       ),
    .rstn_i   ( rstn_i      ),
    .req_i    ( l2_req_o    ),
    .addr_i   ( l2_addr_o   ),
    .we_i     ( l2_we_o     ),
    .be_i     ( l2_be_o     ),
    .wdata_i  ( l2_wdata_o  ),
    .gnt_o    ( l2_gnt_i    ),
    .rvalid_o ( l2_rvalid_i ),
    .rdata_o  ( l2_rdata_i  ),
    .err_o    ( l2_err_i    )
  );

  assign head_rdata = exp_rdata[rd_ptr];
  assign head_err   = exp_err[rd_ptr];
  assign acc        = data_req_i && data_gnt_o;
  assign acc_local  = acc && !((data_addr_i >= `TILE_L2_START) && (data_addr_i < `TILE_L2_END));

  always @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) en_q <= 1'b0;
    else         en_q <= tile_enable_i;
  end

  task automatic flag_mismatch(input string sig, input logic [31:0] exp_val,
                               input logic [31:0] got);
    mismatch_cnt++;
    $display("Mismatch at %0t: %s expected %h got %h", $time, sig, exp_val, got);
  endtask

  task automatic log_failure(input string what);
    other_cnt++;
    $display("Error at %0t: %s", $time, what);
  endtask

  task automatic print_summary();
    $display("Summary: %0d mismatches, %0d other errors, %0d responses checked",
             mismatch_cnt, other_cnt, rsp_cnt);
  endtask

  function automatic logic [31:0] l1_word_addr(input row_idx_t row, input bank_idx_t bank);
    return `TILE_L1_START + {22'd0, row, bank, 2'b00};  // Bank in bits 3:2, row in 9:4
  endfunction

  // Reference model, applied at acceptance
  task automatic predict_response(input logic [31:0] addr, input logic we, input logic [3:0] be,
                                  input logic [31:0] wdata, output logic [31:0] rdata,
                                  output logic err, output logic to_l2);
    logic [31:0] word;
    rdata = '0;                  // Writes and errors answer zero
    err   = 1'b0;
    to_l2 = 1'b0;
    if ((addr >= `TILE_L1_START) && (addr < `TILE_L1_END)) begin
      word = l1_ref[addr[9:2]];
      for (int k = 0; k < 4; k++) begin
        if (we && be[k]) word[8*k +: 8] = wdata[8*k +: 8];
      end
      if (we) l1_ref[addr[9:2]] = word;
      else    rdata = word;
    end else if ((addr >= `TILE_L2_START) && (addr < `TILE_L2_END)) begin
      to_l2 = 1'b1;
      word  = l2_ref.exists(addr) ? l2_ref[addr] : (addr ^ L2_FILL_KEY);
      for (int k = 0; k < 4; k++) begin
        if (we && be[k]) word[8*k +: 8] = wdata[8*k +: 8];
      end
      if (we) l2_ref[addr] = word;
      else    rdata = word;
    end else begin
      err = 1'b1;                // No rule matched
    end
  endtask

  // Push on acceptance, pop on response
  always @(posedge clk_i) begin : track_responses
    logic [31:0] rdata;
    logic        err;
    logic        to_l2;
    logic        push;
    logic        pop;
    push = rstn_i && acc;
    pop  = rstn_i && data_rvalid_o && (exp_cnt != 0);
    if (push) begin
      predict_response(data_addr_i, data_we_i, data_be_i, data_wdata_i, rdata, err, to_l2);
      exp_rdata[wr_ptr] <= rdata;
      exp_err[wr_ptr]   <= err;
      exp_l2[wr_ptr]    <= to_l2;
      wr_ptr            <= wr_ptr + 8'd1;
      if (to_l2) l2_pend <= 1'b1;
    end
    if (pop) begin
      rd_ptr  <= rd_ptr + 8'd1;
      rsp_cnt <= rsp_cnt + 1;
      if (exp_l2[rd_ptr]) l2_pend <= 1'b0;
    end
    exp_cnt <= exp_cnt + int'(push) - int'(pop);
  end

  a_reset_quiet: assert property (@(posedge clk_i)
    !rstn_i |-> (!data_gnt_o && !data_rvalid_o && !l2_req_o))
    else log_failure("grant, response or L2 request active during reset");

  a_rsp_expected: assert property (@(posedge clk_i) disable iff (!rstn_i)
    data_rvalid_o |-> (exp_cnt != 0))
    else log_failure("response arrived with no request outstanding");

  a_rdata: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (data_rvalid_o && (exp_cnt != 0)) |-> (data_rdata_o == head_rdata))
    else flag_mismatch("data_rdata_o", $sampled(head_rdata), $sampled(data_rdata_o));

  a_err: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (data_rvalid_o && (exp_cnt != 0)) |-> (data_err_o == head_err))
    else flag_mismatch("data_err_o", 32'($sampled(head_err)), 32'($sampled(data_err_o)));

  a_local_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
    acc_local |=> data_rvalid_o)
    else log_failure("L1 or decode-error response not one cycle after its grant");

  a_gnt_when_free: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (data_req_i && en_q && !l2_pend) |-> data_gnt_o)
    else log_failure("request not granted while enabled and L2 idle");

  a_no_gnt_disabled: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !en_q |-> !data_gnt_o)
    else log_failure("grant given while the tile was disabled");

  a_no_gnt_l2_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
    l2_pend |-> !data_gnt_o)
    else log_failure("grant given while an L2 transaction was outstanding");

  a_l2_req_follows: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (acc && !acc_local) |=> l2_req_o)
    else log_failure("L2 request not raised one cycle after acceptance");

  a_no_stray_l2: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !l2_pend |-> !l2_req_o)
    else log_failure("L2 request raised without an accepted L2 access");

  // Starts and ends on a rising edge, returns on the accepting edge
  task automatic drive_request(input logic [31:0] addr, input logic we, input logic [3:0] be,
                               input logic [31:0] wdata);
    #10;
    data_req_i   = 1'b1;
    data_addr_i  = addr;
    data_we_i    = we;
    data_be_i    = be;
    data_wdata_i = wdata;
    @(posedge clk_i);
    while (!data_gnt_o) @(posedge clk_i);
  endtask

  task automatic release_bus();
    #10;
    data_req_i = 1'b0;
    data_we_i  = 1'b0;
    @(posedge clk_i);
  endtask

  task automatic wait_drain();
    do @(posedge clk_i); while ((exp_cnt != 0) || l2_pend);
  endtask

  task automatic l1_write_read();
    drive_request(l1_word_addr(6'd63, 2'd3), 1'b0, 4'hf, '0);  // Unwritten, all ones
    for (int i = 0; i < 24; i++) begin
      drive_request(l1_word_addr(6'(i * 7 / 4), 2'(i * 7)), 1'b1, 4'($urandom), $urandom);
    end
    for (int i = 0; i < 24; i++) begin    // Back-to-back reads
      drive_request(l1_word_addr(6'(i * 7 / 4), 2'(i * 7)), 1'b0, 4'hf, '0);
    end
    release_bus();
    wait_drain();
  endtask

  task automatic l2_traffic();
    for (int i = 0; i < 8; i++) begin
      drive_request(`TILE_L2_START + 32'(i * 16), 1'b1, 4'($urandom), $urandom);
    end
    for (int i = 0; i < 9; i++) begin     // Last one never written
      drive_request(`TILE_L2_START + 32'(i * 16), 1'b0, 4'hf, '0);
    end
    release_bus();
    wait_drain();
  endtask

  task automatic unmapped_access();
    logic [31:0] bad [5] = '{32'h0000_0000, `TILE_L1_END, 32'h7fff_fffc, `TILE_L2_END,
                             32'hffff_fff0};
    for (int i = 0; i < 5; i++) begin
      drive_request(bad[i], 1'(i % 2), 4'hf, $urandom);
    end
    release_bus();
    wait_drain();
  endtask

  task automatic enable_gating();
    #10;
    tile_enable_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #10;
    data_req_i  = 1'b1;            // Held with the tile off
    data_addr_i = l1_word_addr(6'd4, 2'd1);
    data_we_i   = 1'b0;
    data_be_i   = 4'hf;
    repeat (4) @(posedge clk_i);
    #10;
    tile_enable_i = 1'b1;
    @(posedge clk_i);
    while (!data_gnt_o) @(posedge clk_i);
    release_bus();
    wait_drain();
  endtask

  task automatic mixed_stream();
    int unsigned pick;
    logic [31:0] rnd;
    logic [31:0] addr;
    for (int i = 0; i < 40; i++) begin
      pick = $urandom_range(0, 9);
      rnd  = $urandom;
      if (pick < 5)      addr = `TILE_L1_START + {22'd0, rnd[7:0], 2'b00};
      else if (pick < 8) addr = `TILE_L2_START + {24'd0, rnd[7:4], 4'd0};
      else               addr = {4'h4, rnd[27:2], 2'b00};      // Unmapped hole
      drive_request(addr, rnd[31], rnd[11:8], $urandom);
    end
    release_bus();
    wait_drain();
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      log_failure("run did not finish within the cycle limit");
      print_summary();
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin : stimulus
    void'($urandom(32'hb707));
    rstn_i        = 1'b0;
    tile_enable_i = 1'b1;
    data_req_i    = 1'b1;            // Held through reset, no grant until enabled
    data_addr_i   = l1_word_addr(6'd62, 2'd0);
    data_we_i     = 1'b0;
    data_be_i     = 4'hf;
    data_wdata_i  = '0;
    repeat (8) @(posedge clk_i);
    #10;
    rstn_i = 1'b1;
    @(posedge clk_i);
    while (!data_gnt_o) @(posedge clk_i);   // Enable register set one cycle after reset
    release_bus();
    l1_write_read();
    l2_traffic();
    unmapped_access();
    enable_gating();
    mixed_stream();
    repeat (3) @(posedge clk_i);
    print_summary();
    if ((mismatch_cnt == 0) && (other_cnt == 0)) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== verification/tb_l2_memory.sv ====
// Behavioral L2 memory for the compute tile testbench
// Random grant and response delays, one transaction at a time,
// sparse memory with an address-derived fill for unwritten words

`timescale 1ns/100ps

module tb_l2_memory (
  input  logic        clk_i,
  input  logic        rstn_i,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o
);

  localparam logic [31:0] FILL_KEY = 32'hc3a5_5a3c;  // Unwritten word is addr ^ key

  logic [31:0] mem [logic [31:0]];   // Written words only
  logic [31:0] addr_q;
  logic        we_q;
  logic [3:0]  be_q;
  logic [31:0] wdata_q;
  logic [31:0] word;

  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;                 // L2 never reports a bus error here
    forever begin
      @(posedge clk_i);
      if (rstn_i && req_i) begin
        repeat ($urandom_range(0, 3)) @(posedge clk_i);  // Grant delay
        #10;
        gnt_o = 1'b1;
        @(posedge clk_i);            // Request taken on this edge
        addr_q  = addr_i;
        we_q    = we_i;
        be_q    = be_i;
        wdata_q = wdata_i;
        #10;
        gnt_o = 1'b0;
        repeat ($urandom_range(0, 3)) begin   // Response delay
          @(posedge clk_i);
          #10;
        end
        word = mem.exists(addr_q) ? mem[addr_q] : (addr_q ^ FILL_KEY);
        if (we_q) begin
          for (int k = 0; k < 4; k++) begin
            if (be_q[k]) word[8*k +: 8] = wdata_q[8*k +: 8];
          end
          mem[addr_q] = word;
          rdata_o     = '0;
        end else begin
          rdata_o = word;
        end
        rvalid_o = 1'b1;
        @(posedge clk_i);
        #10;
        rvalid_o = 1'b0;
        rdata_o  = '0;
      end
    end
  end

endmodule

// ==== src/compute_tile.sv ====
// Compute tile memory side
// Registered tile enable, address demux, banked L1 scratchpad and the L2 bridge

`timescale 1ns/100ps

module compute_tile (
  input  logic                clk_i,
  input  logic                rstn_i,
  input  logic                tile_enable_i,
  // Data request port
  input  logic                data_req_i,
  input  tile_bus_pkg::addr_t data_addr_i,
  input  logic                data_we_i,
  input  tile_bus_pkg::be_t   data_be_i,
  input  tile_bus_pkg::word_t data_wdata_i,
  output logic                data_gnt_o,
  output logic                data_rvalid_o,
  output tile_bus_pkg::word_t data_rdata_o,
  output logic                data_err_o,
  // External L2 port
  output logic                l2_req_o,
  output tile_bus_pkg::addr_t l2_addr_o,
  output logic                l2_we_o,
  output tile_bus_pkg::be_t   l2_be_o,
  output tile_bus_pkg::word_t l2_wdata_o,
  input  logic                l2_gnt_i,
  input  logic                l2_rvalid_i,
  input  tile_bus_pkg::word_t l2_rdata_i,
  input  logic                l2_err_i
);

  import tile_bus_pkg::*;

  logic  sys_en;       // Clock enable for the whole tile
  logic  l1_acc;
  logic  l2_acc;
  logic  l1_rvalid;
  word_t l1_rdata;
  logic  l2_busy;
  logic  l2_rvalid;
  word_t l2_rdata;
  logic  l2_err;

  // Enable takes effect one cycle after the input
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      sys_en <= 1'b0;
    end else begin
      sys_en <= tile_enable_i;
    end
  end

  tile_addr_demux i_addr_demux (
    .clk_i       ( clk_i         ),
    .rstn_i      ( rstn_i        ),
    .en_i        ( sys_en        ),
    .req_i       ( data_req_i    ),
    .addr_i      ( data_addr_i   ),
    .we_i        ( data_we_i     ),
    .be_i        ( data_be_i     ),
    .wdata_i     ( data_wdata_i  ),
    .l1_rvalid_i ( l1_rvalid     ),
    .l1_rdata_i  ( l1_rdata      ),
    .l2_busy_i   ( l2_busy       ),
    .l2_rvalid_i ( l2_rvalid     ),
    .l2_rdata_i  ( l2_rdata      ),
    .l2_err_i    ( l2_err        ),
    .gnt_o       ( data_gnt_o    ),
    .l1_acc_o    ( l1_acc        ),
    .l2_acc_o    ( l2_acc        ),
    .rvalid_o    ( data_rvalid_o ),
    .rdata_o     ( data_rdata_o  ),
    .err_o       ( data_err_o    )
  );

  l1_spm i_l1_spm (
    .clk_i    ( clk_i        ),
    .rstn_i   ( rstn_i       ),
    .en_i     ( sys_en       ),
    .acc_i    ( l1_acc       ),
    .addr_i   ( data_addr_i  ),   // Shared request payload
    .we_i     ( data_we_i    ),
    .be_i     ( data_be_i    ),
    .wdata_i  ( data_wdata_i ),
    .rvalid_o ( l1_rvalid    ),
    .rdata_o  ( l1_rdata     )
  );

  l2_bridge i_l2_bridge (
    .clk_i       ( clk_i        ),
    .rstn_i      ( rstn_i       ),
    .en_i        ( sys_en       ),
    .acc_i       ( l2_acc       ),
    .addr_i      ( data_addr_i  ),
    .we_i        ( data_we_i    ),
    .be_i        ( data_be_i    ),
    .wdata_i     ( data_wdata_i ),
    .l2_gnt_i    ( l2_gnt_i     ),
    .l2_rvalid_i ( l2_rvalid_i  ),
    .l2_rdata_i  ( l2_rdata_i   ),
    .l2_err_i    ( l2_err_i     ),
    .busy_o      ( l2_busy      ),
    .rvalid_o    ( l2_rvalid    ),
    .rdata_o     ( l2_rdata     ),
    .err_o       ( l2_err       ),
    .l2_req_o    ( l2_req_o     ),
    .l2_addr_o   ( l2_addr_o    ),
    .l2_we_o     ( l2_we_o      ),
    .l2_be_o     ( l2_be_o      ),
    .l2_wdata_o  ( l2_wdata_o   )
  );

endmodule

// ==== src/l2_bridge.sv ====
// L2 bridge of the compute tile
// Single-outstanding req/gnt/rvalid master toward the external L2,
// idle, request and wait states with holding registers for the request

`timescale 1ns/100ps

module l2_bridge (
  input  logic                clk_i,
  input  logic                rstn_i,
  input  logic                en_i,
  input  logic                acc_i,       // Accepted L2 request
  input  tile_bus_pkg::addr_t addr_i,
  input  logic                we_i,
  input  tile_bus_pkg::be_t   be_i,
  input  tile_bus_pkg::word_t wdata_i,
  input  logic                l2_gnt_i,
  input  logic                l2_rvalid_i,
  input  tile_bus_pkg::word_t l2_rdata_i,
  input  logic                l2_err_i,
  output logic                busy_o,      // Slot taken, demux holds off
  output logic                rvalid_o,
  output tile_bus_pkg::word_t rdata_o,
  output logic                err_o,
  output logic                l2_req_o,
  output tile_bus_pkg::addr_t l2_addr_o,
  output logic                l2_we_o,
  output tile_bus_pkg::be_t   l2_be_o,
  output tile_bus_pkg::word_t l2_wdata_o
);

  import tile_bus_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,    // Slot free
    ST_REQ  = 2'd1,    // Presenting, waiting for grant
    ST_WAIT = 2'd2     // Granted, waiting for rvalid
  } state_e;

  state_e state_q;
  state_e state_d;
  addr_t  addr_q;
  logic   we_q;
  be_t    be_q;
  word_t  wdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (acc_i)       state_d = ST_REQ;
      ST_REQ:  if (l2_gnt_i)    state_d = ST_WAIT;
      ST_WAIT: if (l2_rvalid_i) state_d = ST_IDLE;
      default:                  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q <= ST_IDLE;
    end else if (en_i) begin
      state_q <= state_d;      // Frozen while the tile is disabled
    end
  end

  // Capture on accept, held until the next one
  always_ff @(posedge clk_i) begin
    if (en_i && acc_i && (state_q == ST_IDLE)) begin
      addr_q  <= addr_i;
      we_q    <= we_i;
      be_q    <= be_i;
      wdata_q <= wdata_i;
    end
  end

  assign busy_o     = (state_q != ST_IDLE);
  assign l2_req_o   = (state_q == ST_REQ);
  assign l2_addr_o  = addr_q;
  assign l2_we_o    = we_q;
  assign l2_be_o    = be_q;
  assign l2_wdata_o = wdata_q;

  // Response passes through in the cycle it arrives
  assign rvalid_o = en_i && (state_q == ST_WAIT) && l2_rvalid_i;
  assign rdata_o  = we_q ? '0 : l2_rdata_i;
  assign err_o    = rvalid_o && l2_err_i;

  // Held request must not move before L2 takes it
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (l2_req_o && !l2_gnt_i) |=>
      (l2_req_o && $stable({l2_addr_o, l2_we_o, l2_be_o, l2_wdata_o})));

  // External L2 answers only what it was granted
  a_no_rsp_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (state_q == ST_IDLE) |-> !l2_rvalid_i);

endmodule

// ==== src/l1_spm.sv ====
// L1 scratchpad of the compute tile
// Word-interleaved banks, all ones at power-up, byte-enable writes
// and a one-cycle registered read response

`timescale 1ns/100ps

`include "tile_cfg.svh"

module l1_spm (
  input  logic                clk_i,
  input  logic                rstn_i,
  input  logic                en_i,
  input  logic                acc_i,     // Accepted L1 request
  input  tile_bus_pkg::addr_t addr_i,
  input  logic                we_i,
  input  tile_bus_pkg::be_t   be_i,
  input  tile_bus_pkg::word_t wdata_i,
  output logic                rvalid_o,
  output tile_bus_pkg::word_t rdata_o
);

  import tile_bus_pkg::*;
  import tile_addr_pkg::*;

  logic      access;                          // Request reaches the banks this cycle
  bank_idx_t bank_sel;
  row_idx_t  row_sel;
  bank_idx_t bank_q;                          // Bank of the pending response
  logic      we_q;                            // Pending response is a write
  logic      rvalid_q;
  word_t     bank_rdata [`TILE_N_BANKS];      // Per-bank read registers

  assign access   = acc_i && en_i;
  assign bank_sel = bank_of(addr_i);
  assign row_sel  = row_of(addr_i);

  for (genvar b = 0; b < `TILE_N_BANKS; b++) begin : g_bank
    word_t bank_mem [`TILE_BANK_WORDS] = '{default: '1};  // Power-up fill

    always_ff @(posedge clk_i) begin
      if (access && (bank_sel == bank_idx_t'(b))) begin
        if (we_i) begin
          for (int k = 0; k < BE_W; k++) begin
            if (be_i[k]) begin
              bank_mem[row_sel][8*k +: 8] <= wdata_i[8*k +: 8];  // Enabled bytes only
            end
          end
        end else begin
          bank_rdata[b] <= bank_mem[row_sel];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= access;        // Every access answers next cycle
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      bank_q <= bank_sel;
      we_q   <= we_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = we_q ? '0 : bank_rdata[bank_q];   // Writes answer with zero

  // Demux only steers accepts while the tile is enabled
  a_no_acc_disabled: assert property (@(posedge clk_i) disable iff (!rstn_i)
    acc_i |-> en_i);

endmodule

// ==== src/tile_addr_demux.sv ====
// Address demux of the compute tile
// Decodes each request against the L1 and L2 rules, grants it, steers the accept strobe,
// keeps the target of the last accept and merges the three response sources

`timescale 1ns/100ps

`include "tile_cfg.svh"

module tile_addr_demux (
  input  logic                clk_i,
  input  logic                rstn_i,
  input  logic                en_i,         // Registered tile enable
  input  logic                req_i,
  input  tile_bus_pkg::addr_t addr_i,
  input  logic                we_i,
  input  tile_bus_pkg::be_t   be_i,
  input  tile_bus_pkg::word_t wdata_i,
  input  logic                l1_rvalid_i,
  input  tile_bus_pkg::word_t l1_rdata_i,
  input  logic                l2_busy_i,    // L2 transaction outstanding
  input  logic                l2_rvalid_i,
  input  tile_bus_pkg::word_t l2_rdata_i,
  input  logic                l2_err_i,
  output logic                gnt_o,
  output logic                l1_acc_o,     // Accepted, goes to L1
  output logic                l2_acc_o,     // Accepted, goes to L2
  output logic                rvalid_o,
  output tile_bus_pkg::word_t rdata_o,
  output logic                err_o
);

  import tile_bus_pkg::*;
  import tile_addr_pkg::*;

  target_e tgt;        // Decoded target of the current request
  target_e tgt_q;      // Target of the last accepted request
  logic    err_acc;    // Accepted, no rule matched
  logic    err_q;      // One-cycle decode-error response
  logic    hit_l1;
  logic    hit_l2;

  // Region compare, end bound exclusive
  assign hit_l1 = (addr_i >= `TILE_L1_START) && (addr_i < `TILE_L1_END);
  assign hit_l2 = (addr_i >= `TILE_L2_START) && (addr_i < `TILE_L2_END);

  always_comb begin
    if (hit_l1) begin
      tgt = TGT_L1;
    end else if (hit_l2) begin
      tgt = TGT_L2;
    end else begin
      tgt = TGT_ERR;   // Falls through both rules
    end
  end

  // No new request while the L2 bridge holds its single slot
  assign gnt_o    = req_i && en_i && !l2_busy_i;
  assign l1_acc_o = gnt_o && (tgt == TGT_L1);
  assign l2_acc_o = gnt_o && (tgt == TGT_L2);
  assign err_acc  = gnt_o && (tgt == TGT_ERR);

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      tgt_q <= TGT_ERR;
      err_q <= 1'b0;
    end else begin
      err_q <= err_acc;          // Error answers one cycle later
      if (gnt_o) begin
        tgt_q <= tgt;            // Holds while L2 is outstanding
      end
    end
  end

  // Response merge, sources never overlap
  assign rvalid_o = l1_rvalid_i || l2_rvalid_i || err_q;
  assign err_o    = err_q || (l2_rvalid_i && l2_err_i);

  always_comb begin
    case (tgt_q)
      TGT_L1:  rdata_o = l1_rdata_i;
      TGT_L2:  rdata_o = l2_rdata_i;
      default: rdata_o = '0;     // Decode error returns zero
    endcase
  end

  // One response per cycle across L1, L2 and the error path
  a_one_rsp: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $onehot0({l1_rvalid_i, l2_rvalid_i, err_q}));

  // Bridge must raise busy right after an L2 accept so the next request waits
  a_l2_backpressure: assert property (@(posedge clk_i) disable iff (!rstn_i)
    l2_acc_o |=> (l2_busy_i && !gnt_o));

endmodule

// ==== src/tile_addr_pkg.sv ====
// Address map types for the compute tile
// Target enumeration, bank and row index types and the index extraction helpers

`include "tile_cfg.svh"

package tile_addr_pkg;

  localparam int unsigned BANK_IDX_W = $clog2(`TILE_N_BANKS);     // Bank select bits
  localparam int unsigned ROW_IDX_W  = $clog2(`TILE_BANK_WORDS);  // Word-in-bank bits
  localparam int unsigned WORD_OFS_W = 2;                         // Byte offset inside a word

  typedef enum logic [1:0] {
    TGT_L1  = 2'd0,                        // Local scratchpad
    TGT_L2  = 2'd1,                        // External L2 port
    TGT_ERR = 2'd2                         // No rule matched
  } target_e;

  typedef logic [BANK_IDX_W-1:0] bank_idx_t;  // Address bits 3:2
  typedef logic [ROW_IDX_W-1:0]  row_idx_t;   // Address bits 9:4

  // Lowest word bits pick the bank, so consecutive words hit different banks
  function automatic bank_idx_t bank_of(input logic [`TILE_ADDR_W-1:0] addr);
    return addr[WORD_OFS_W +: BANK_IDX_W];
  endfunction

  function automatic row_idx_t row_of(input logic [`TILE_ADDR_W-1:0] addr);
    return addr[WORD_OFS_W + BANK_IDX_W +: ROW_IDX_W];  // Bits above the bank select
  endfunction

endpackage

// ==== src/tile_bus_pkg.sv ====
// Bus payload types for the compute tile
// Address, data word and byte-enable types of the req/gnt/rvalid bus

`include "tile_cfg.svh"

package tile_bus_pkg;

  localparam int unsigned ADDR_W = `TILE_ADDR_W;   // Address width
  localparam int unsigned DATA_W = `TILE_DATA_W;   // Word width
  localparam int unsigned BE_W   = DATA_W / 8;     // One enable per byte

  typedef logic [ADDR_W-1:0] addr_t;   // Byte address
  typedef logic [DATA_W-1:0] word_t;   // Read and write data
  typedef logic [BE_W-1:0]   be_t;     // Byte enables, bit k covers bits 8k+7:8k

  // A request is accepted on req && gnt
  // Each accepted request returns one rvalid pulse, in order
  // Write responses carry zero rdata

endpackage

// ==== src/tile_cfg.svh ====
// Compute tile configuration macros
// Address and data widths, L1 bank geometry and the address map bounds
// Region ends are exclusive

`ifndef TILE_CFG_SVH
`define TILE_CFG_SVH

// Bus widths
`define TILE_ADDR_W      32                // Byte address width
`define TILE_DATA_W      32                // Data word width

// L1 scratchpad geometry
`define TILE_N_BANKS     4                 // Word-interleaved banks
`define TILE_BANK_WORDS  64                // Words per bank

// L1 region, 1 KiB
`define TILE_L1_START    32'h1000_0000     // First L1 byte
`define TILE_L1_END      32'h1000_0400     // One past the last L1 byte

// L2 region, 256 MiB behind the external port
`define TILE_L2_START    32'h8000_0000     // First L2 byte
`define TILE_L2_END      32'h9000_0000     // One past the last L2 byte

`endif
